// File: hw/decode_pkg.sv
/*
 * Shared encodings for the x86 field decoder. Holds widths, opcode
 * constants, position selects and the two pipeline payloads.
 */
package decode_pkg;

    // ========================================
    // Widths
    // ========================================
    localparam int BYTE_W       = 8;
    localparam int WINDOW_BYTES = 3;
    localparam int GPR_W        = 3;
    localparam int SREG3_W      = 3;
    localparam int SREG2_W      = 2;
    localparam int MOD_W        = 2;
    localparam int RM_W         = 3;

    // ========================================
    // Opcodes
    // ========================================
    localparam logic [BYTE_W-1:0] OP_ESCAPE           = 8'h0F;
    localparam logic [BYTE_W-1:0] OP_IMM_GRP_LO       = 8'h80;
    localparam logic [BYTE_W-1:0] OP_IMM_GRP_HI       = 8'h83;
    localparam logic [BYTE_W-1:0] OP_MOV_RM_LO        = 8'h88;
    localparam logic [BYTE_W-1:0] OP_MOV_RM_HI        = 8'h8B;
    localparam logic [BYTE_W-1:0] OP_MOV_SREG_TO      = 8'h8C;
    localparam logic [BYTE_W-1:0] OP_MOV_SREG_FROM    = 8'h8E;
    localparam logic [BYTE_W-1:0] OP_MOV_IMM_SHORT_LO = 8'hB0;
    localparam logic [BYTE_W-1:0] OP_MOV_IMM_SHORT_HI = 8'hBF;
    localparam logic [BYTE_W-1:0] OP_SHORT_REG_LO     = 8'h40; // INC, DEC, PUSH, POP.
    localparam logic [BYTE_W-1:0] OP_SHORT_REG_HI     = 8'h5F;

    // Second byte after the escape.
    localparam logic [BYTE_W-1:0] OP2_SETCC_LO = 8'h90;
    localparam logic [BYTE_W-1:0] OP2_SETCC_HI = 8'h9F;
    localparam logic [BYTE_W-1:0] OP2_MOVZX_LO = 8'hB6;
    localparam logic [BYTE_W-1:0] OP2_MOVZX_HI = 8'hB7;
    localparam logic [BYTE_W-1:0] OP2_MOVSX_LO = 8'hBE;
    localparam logic [BYTE_W-1:0] OP2_MOVSX_HI = 8'hBF;
    localparam logic [BYTE_W-1:0] OP2_BSF      = 8'hBC;
    localparam logic [BYTE_W-1:0] OP2_BSR      = 8'hBD;
    localparam logic [BYTE_W-1:0] OP2_PUSH_FS  = 8'hA0;
    localparam logic [BYTE_W-1:0] OP2_POP_FS   = 8'hA1;
    localparam logic [BYTE_W-1:0] OP2_PUSH_GS  = 8'hA8;
    localparam logic [BYTE_W-1:0] OP2_POP_GS   = 8'hA9;

    // ========================================
    // Position selects
    // ========================================
    typedef enum logic [1:0] {W_NONE, W_B0_BIT0, W_B0_BIT3, W_B1_BIT0} w_pos_e;
    typedef enum logic [1:0] {REG_NONE, REG_B0_LOW, REG_B1_MID, REG_B2_MID} reg_pos_e;
    typedef enum logic [1:0] {MODRM_NONE, MODRM_B1, MODRM_B2} modrm_pos_e;

    // First stage output. Window byte 0 sits in the low slot.
    typedef struct packed {
        logic                                 recognized;
        logic                                 s_sel;
        logic                                 sreg3_sel;
        logic                                 sreg2_sel;
        w_pos_e                               w_pos;
        reg_pos_e                             reg_pos;
        modrm_pos_e                           modrm_pos;
        logic [WINDOW_BYTES-1:0][BYTE_W-1:0] window;
    } sel_payload_t;

    typedef struct packed {
        logic               recognized;
        logic               s;
        logic               w;
        logic [GPR_W-1:0]   gpr;
        logic [SREG3_W-1:0] sreg3;
        logic [SREG2_W-1:0] sreg2;
        logic [MOD_W-1:0]   mod;
        logic [RM_W-1:0]    rm;
    } field_payload_t;

endpackage

// File: hw/opcode_classify.sv
/*
 * Opcode classifier. Looks at the opcode byte, and the second byte
 * after the 0x0F escape, and says where each field of the form sits.
 */
module opcode_classify (
    input  logic [decode_pkg::BYTE_W-1:0] byte0,
    input  logic [decode_pkg::BYTE_W-1:0] byte1,
    output logic                          recognized,
    output logic                          s_sel,
    output logic                          sreg3_sel,
    output logic                          sreg2_sel,
    output decode_pkg::w_pos_e            w_pos,
    output decode_pkg::reg_pos_e          reg_pos,
    output decode_pkg::modrm_pos_e        modrm_pos
);

    logic escape;
    logic alu_rm;
    logic alu_acc;
    logic sreg2_stack;
    logic short_reg;
    logic imm_grp;
    logic mov_rm;
    logic mov_sreg;
    logic mov_imm_short;
    logic ext_movx;
    logic ext_bitscan;
    logic ext_setcc;
    logic ext_fs_gs;

    // ========================================
    // One-byte forms
    // ========================================
    assign escape = byte0 == decode_pkg::OP_ESCAPE;

    // 0x00-0x3F, low bits 0-3 carry a mod/rm byte, 4-5 use the accumulator.
    assign alu_rm  = byte0[7:6] == 2'b00 && byte0[2] == 1'b0;
    assign alu_acc = byte0[7:6] == 2'b00 && byte0[2:1] == 2'b10;

    // Low bits 6-7 below 0x20, except the escape itself.
    assign sreg2_stack = byte0[7:5] == 3'b000 && byte0[2:1] == 2'b11 && !escape;

    assign short_reg = byte0 inside {[decode_pkg::OP_SHORT_REG_LO:decode_pkg::OP_SHORT_REG_HI]};
    assign imm_grp   = byte0 inside {[decode_pkg::OP_IMM_GRP_LO:decode_pkg::OP_IMM_GRP_HI]};
    assign mov_rm    = byte0 inside {[decode_pkg::OP_MOV_RM_LO:decode_pkg::OP_MOV_RM_HI]};
    assign mov_sreg  = byte0 == decode_pkg::OP_MOV_SREG_TO ||
                       byte0 == decode_pkg::OP_MOV_SREG_FROM;
    assign mov_imm_short = byte0 inside
        {[decode_pkg::OP_MOV_IMM_SHORT_LO:decode_pkg::OP_MOV_IMM_SHORT_HI]};

    // ========================================
    // Escape forms
    // ========================================
    assign ext_movx = escape && byte1 inside
        {[decode_pkg::OP2_MOVZX_LO:decode_pkg::OP2_MOVZX_HI],
         [decode_pkg::OP2_MOVSX_LO:decode_pkg::OP2_MOVSX_HI]};
    assign ext_bitscan = escape &&
        (byte1 == decode_pkg::OP2_BSF || byte1 == decode_pkg::OP2_BSR);
    assign ext_setcc = escape &&
        byte1 inside {[decode_pkg::OP2_SETCC_LO:decode_pkg::OP2_SETCC_HI]};
    assign ext_fs_gs = escape && byte1 inside
        {decode_pkg::OP2_PUSH_FS, decode_pkg::OP2_POP_FS,
         decode_pkg::OP2_PUSH_GS, decode_pkg::OP2_POP_GS};

    assign recognized = alu_rm | alu_acc | sreg2_stack | short_reg | imm_grp |
                        mov_rm | mov_sreg | mov_imm_short |
                        ext_movx | ext_bitscan | ext_setcc | ext_fs_gs;

    // Forms are disjoint, so the order below only sets priority on paper.
    always_comb begin
        s_sel     = 1'b0;
        sreg3_sel = 1'b0;
        sreg2_sel = 1'b0;
        w_pos     = decode_pkg::W_NONE;
        reg_pos   = decode_pkg::REG_NONE;
        modrm_pos = decode_pkg::MODRM_NONE;
        if (alu_rm || mov_rm) begin
            w_pos     = decode_pkg::W_B0_BIT0;
            reg_pos   = decode_pkg::REG_B1_MID;
            modrm_pos = decode_pkg::MODRM_B1;
        end else if (alu_acc) begin
            w_pos = decode_pkg::W_B0_BIT0;
        end else if (sreg2_stack) begin
            sreg2_sel = 1'b1;
        end else if (short_reg) begin
            reg_pos = decode_pkg::REG_B0_LOW;
        end else if (imm_grp) begin
            s_sel     = 1'b1;
            w_pos     = decode_pkg::W_B0_BIT0;
            modrm_pos = decode_pkg::MODRM_B1;
        end else if (mov_sreg) begin
            sreg3_sel = 1'b1;
            modrm_pos = decode_pkg::MODRM_B1;
        end else if (mov_imm_short) begin
            w_pos   = decode_pkg::W_B0_BIT3;
            reg_pos = decode_pkg::REG_B0_LOW;
        end else if (ext_movx) begin
            w_pos     = decode_pkg::W_B1_BIT0;
            reg_pos   = decode_pkg::REG_B2_MID;
            modrm_pos = decode_pkg::MODRM_B2;
        end else if (ext_bitscan) begin
            reg_pos   = decode_pkg::REG_B2_MID;
            modrm_pos = decode_pkg::MODRM_B2;
        end else if (ext_setcc) begin
            modrm_pos = decode_pkg::MODRM_B2;
        end else if (ext_fs_gs) begin
            sreg3_sel = 1'b1; // FS or GS in byte1 bits 5:3.
        end
    end

endmodule

// File: hw/field_extract.sv
/*
 * Field picker. Reads each field out of the held byte window at the
 * position chosen by the classifier; absent fields read as zero.
 */
module field_extract (
    input  decode_pkg::sel_payload_t   sel,
    output decode_pkg::field_payload_t fields
);

    logic [decode_pkg::BYTE_W-1:0] byte0;
    logic [decode_pkg::BYTE_W-1:0] byte1;
    logic [decode_pkg::BYTE_W-1:0] byte2;
    logic [decode_pkg::BYTE_W-1:0] modrm;
    logic                          has_modrm;

    assign byte0 = sel.window[0];
    assign byte1 = sel.window[1];
    assign byte2 = sel.window[2];

    // Mod/rm byte follows the opcode, one further after the escape.
    always_comb begin
        modrm     = '0;
        has_modrm = 1'b0;
        case (sel.modrm_pos)
            decode_pkg::MODRM_B1: begin
                modrm     = byte1;
                has_modrm = 1'b1;
            end
            decode_pkg::MODRM_B2: begin
                modrm     = byte2;
                has_modrm = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        fields = '0;
        fields.recognized = sel.recognized;

        if (sel.s_sel) fields.s = byte0[1]; // Sign-extend bit.

        case (sel.w_pos)
            decode_pkg::W_B0_BIT0: fields.w = byte0[0];
            decode_pkg::W_B0_BIT3: fields.w = byte0[3];
            decode_pkg::W_B1_BIT0: fields.w = byte1[0];
            default:               fields.w = 1'b0;
        endcase

        case (sel.reg_pos)
            decode_pkg::REG_B0_LOW: fields.gpr = byte0[2:0];
            decode_pkg::REG_B1_MID: fields.gpr = byte1[5:3];
            decode_pkg::REG_B2_MID: fields.gpr = byte2[5:3];
            default:                fields.gpr = '0;
        endcase

        // Same slice of byte1 for MOV sreg and for FS/GS push/pop.
        if (sel.sreg3_sel) fields.sreg3 = byte1[5:3];
        if (sel.sreg2_sel) fields.sreg2 = byte0[4:3];

        if (has_modrm) begin
            fields.mod = modrm[7:6];
            fields.rm  = modrm[2:0];
        end
    end

endmodule

// File: hw/pipe_stage.sv
/*
 * One-entry valid/ready register stage for any payload type.
 */
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Take a new item when empty or when the current one leaves now.
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

// File: hw/field_decode_top.sv
/*
 * Two-stage x86 field decoder. Classifies the opcode, registers the
 * selects, picks the fields and registers them for the output port.
 */
module field_decode_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    output logic                           in_ready,
    input  logic [decode_pkg::BYTE_W-1:0]  in_byte0,
    input  logic [decode_pkg::BYTE_W-1:0]  in_byte1,
    input  logic [decode_pkg::BYTE_W-1:0]  in_byte2,
    output logic                           out_valid,
    input  logic                           out_ready,
    output logic                           recognized,
    output logic                           s,
    output logic                           w,
    output logic [decode_pkg::GPR_W-1:0]   gpr,
    output logic [decode_pkg::SREG3_W-1:0] sreg3,
    output logic [decode_pkg::SREG2_W-1:0] sreg2,
    output logic [decode_pkg::MOD_W-1:0]   mod,
    output logic [decode_pkg::RM_W-1:0]    rm
);

    logic                       cls_recognized;
    logic                       cls_s_sel;
    logic                       cls_sreg3_sel;
    logic                       cls_sreg2_sel;
    decode_pkg::w_pos_e         cls_w_pos;
    decode_pkg::reg_pos_e       cls_reg_pos;
    decode_pkg::modrm_pos_e     cls_modrm_pos;
    decode_pkg::sel_payload_t   sel_d;
    decode_pkg::sel_payload_t   sel_q;
    decode_pkg::field_payload_t field_d;
    decode_pkg::field_payload_t field_q;
    logic                       sel_valid;
    logic                       sel_ready;

    // ========================================
    // Stage 1: classify and register selects
    // ========================================
    opcode_classify u_classify (
        .byte0      (in_byte0),
        .byte1      (in_byte1),
        .recognized (cls_recognized),
        .s_sel      (cls_s_sel),
        .sreg3_sel  (cls_sreg3_sel),
        .sreg2_sel  (cls_sreg2_sel),
        .w_pos      (cls_w_pos),
        .reg_pos    (cls_reg_pos),
        .modrm_pos  (cls_modrm_pos)
    );

    assign sel_d = '{recognized: cls_recognized, s_sel: cls_s_sel,
                     sreg3_sel: cls_sreg3_sel, sreg2_sel: cls_sreg2_sel,
                     w_pos: cls_w_pos, reg_pos: cls_reg_pos, modrm_pos: cls_modrm_pos,
                     window: {in_byte2, in_byte1, in_byte0}};

    pipe_stage #(.payload_t(decode_pkg::sel_payload_t)) sel_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (sel_d),
        .out_valid (sel_valid),
        .out_ready (sel_ready),
        .out_data  (sel_q)
    );

    // ========================================
    // Stage 2: extract and register fields
    // ========================================
    field_extract u_extract (
        .sel    (sel_q),
        .fields (field_d)
    );

    pipe_stage #(.payload_t(decode_pkg::field_payload_t)) field_stage (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sel_valid),
        .in_ready  (sel_ready),
        .in_data   (field_d),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (field_q)
    );

    assign recognized = field_q.recognized;
    assign s          = field_q.s;
    assign w          = field_q.w;
    assign gpr        = field_q.gpr;
    assign sreg3      = field_q.sreg3;
    assign sreg2      = field_q.sreg2;
    assign mod        = field_q.mod;
    assign rm         = field_q.rm;

endmodule

// File: bench/field_decode_chk.sv
/*
 * Protocol checker bound into the decoder top level. Covers output
 * hold under back-pressure, reset and unknowns on valid results.
 */
module field_decode_chk (
    input logic                           clk,
    input logic                           reset,
    input logic                           out_valid,
    input logic                           out_ready,
    input logic                           recognized,
    input logic                           s,
    input logic                           w,
    input logic [decode_pkg::GPR_W-1:0]   gpr,
    input logic [decode_pkg::SREG3_W-1:0] sreg3,
    input logic [decode_pkg::SREG2_W-1:0] sreg2,
    input logic [decode_pkg::MOD_W-1:0]   mod,
    input logic [decode_pkg::RM_W-1:0]    rm
);

    decode_pkg::field_payload_t fields;
    int                         fail_count = 0;

    assign fields = {recognized, s, w, gpr, sreg3, sreg2, mod, rm};

    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(fields))
        else begin
            $error("output changed while stalled");
            fail_count++;
        end

    a_reset: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high after reset");
            fail_count++;
        end

    a_known: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> !$isunknown(fields))
        else begin
            $error("unknown bits on a valid result");
            fail_count++;
        end

endmodule

bind field_decode_top field_decode_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .recognized (recognized),
    .s          (s),
    .w          (w),
    .gpr        (gpr),
    .sreg3      (sreg3),
    .sreg2      (sreg2),
    .mod        (mod),
    .rm         (rm)
);

// File: bench/decode_model.svh
/*
 * Reference decoder for the testbench. Works out the expected fields
 * of one byte window straight from the instruction encodings.
 */
function automatic decode_pkg::field_payload_t model_decode(
    input logic [decode_pkg::BYTE_W-1:0] b0,
    input logic [decode_pkg::BYTE_W-1:0] b1,
    input logic [decode_pkg::BYTE_W-1:0] b2
);
    decode_pkg::field_payload_t f;
    f = '0;
    if (b0 == decode_pkg::OP_ESCAPE) begin
        if ((b1 >= decode_pkg::OP2_MOVZX_LO && b1 <= decode_pkg::OP2_MOVZX_HI) ||
            (b1 >= decode_pkg::OP2_MOVSX_LO && b1 <= decode_pkg::OP2_MOVSX_HI)) begin
            f = '{recognized: 1'b1, w: b1[0], gpr: b2[5:3], mod: b2[7:6], rm: b2[2:0],
                  default: '0};
        end else if (b1 == decode_pkg::OP2_BSF || b1 == decode_pkg::OP2_BSR) begin
            f = '{recognized: 1'b1, gpr: b2[5:3], mod: b2[7:6], rm: b2[2:0], default: '0};
        end else if (b1 >= decode_pkg::OP2_SETCC_LO && b1 <= decode_pkg::OP2_SETCC_HI) begin
            f = '{recognized: 1'b1, mod: b2[7:6], rm: b2[2:0], default: '0};
        end else if (b1 == decode_pkg::OP2_PUSH_FS || b1 == decode_pkg::OP2_POP_FS ||
                     b1 == decode_pkg::OP2_PUSH_GS || b1 == decode_pkg::OP2_POP_GS) begin
            f = '{recognized: 1'b1, sreg3: b1[5:3], default: '0};
        end
    end else if (b0 < 8'h40) begin
        // ALU block, the low three bits pick the form.
        if (b0[2:0] <= 3'd3) begin
            f = '{recognized: 1'b1, w: b0[0], gpr: b1[5:3], mod: b1[7:6], rm: b1[2:0],
                  default: '0};
        end else if (b0[2:0] <= 3'd5) begin
            f = '{recognized: 1'b1, w: b0[0], default: '0};
        end else if (b0 == 8'h06 || b0 == 8'h07 || b0 == 8'h0E || b0 == 8'h16 ||
                     b0 == 8'h17 || b0 == 8'h1E || b0 == 8'h1F) begin
            f = '{recognized: 1'b1, sreg2: b0[4:3], default: '0};
        end
    end else if (b0 >= decode_pkg::OP_SHORT_REG_LO && b0 <= decode_pkg::OP_SHORT_REG_HI) begin
        f = '{recognized: 1'b1, gpr: b0[2:0], default: '0};
    end else if (b0 >= decode_pkg::OP_IMM_GRP_LO && b0 <= decode_pkg::OP_IMM_GRP_HI) begin
        f = '{recognized: 1'b1, s: b0[1], w: b0[0], mod: b1[7:6], rm: b1[2:0], default: '0};
    end else if (b0 >= decode_pkg::OP_MOV_RM_LO && b0 <= decode_pkg::OP_MOV_RM_HI) begin
        f = '{recognized: 1'b1, w: b0[0], gpr: b1[5:3], mod: b1[7:6], rm: b1[2:0],
              default: '0};
    end else if (b0 == decode_pkg::OP_MOV_SREG_TO || b0 == decode_pkg::OP_MOV_SREG_FROM) begin
        f = '{recognized: 1'b1, sreg3: b1[5:3], mod: b1[7:6], rm: b1[2:0], default: '0};
    end else if (b0 >= decode_pkg::OP_MOV_IMM_SHORT_LO &&
                 b0 <= decode_pkg::OP_MOV_IMM_SHORT_HI) begin
        f = '{recognized: 1'b1, w: b0[3], gpr: b0[2:0], default: '0};
    end
    return f;
endfunction

// File: bench/field_decode_tb.sv
/*
 * Testbench for the two-stage field decoder. Random byte windows with
 * random handshakes, checked in order against a reference model.
 */
module field_decode_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int SEED         = 41;
    localparam int N_RM         = 40;
    localparam int N_SHORT      = 40;
    localparam int N_ESCAPE     = 40;
    localparam int N_UNKNOWN    = 30;
    localparam int N_MIX        = 100;
    localparam int N_STREAM     = 50;
    localparam int TOTAL        = N_RM + N_SHORT + N_ESCAPE + N_UNKNOWN + N_MIX + N_STREAM;
    localparam int CYCLE_LIMIT  = 4 * TOTAL + 200;

    localparam int KIND_RM      = 0;
    localparam int KIND_SHORT   = 1;
    localparam int KIND_ESCAPE  = 2;
    localparam int KIND_UNKNOWN = 3;
    localparam int KIND_MIX     = 4;

    // Prefixes and BCD adjusts, then escape bytes outside the kept set.
    localparam logic [7:0] UNKNOWN_ONE [16] = '{8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64, 8'h65,
        8'h66, 8'h67, 8'hF0, 8'hF2, 8'hF3, 8'h27, 8'h2F, 8'h37, 8'h3F, 8'hD4};
    localparam logic [7:0] UNKNOWN_ESC [16] = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h06, 8'h20,
        8'h22, 8'h80, 8'hA2, 8'hA3, 8'hAB, 8'hAF, 8'hB3, 8'hBA, 8'hC8, 8'hC0};
    localparam logic [7:0] SREG2_OPS [8] = '{8'h06, 8'h07, 8'h0E, 8'h16, 8'h17, 8'h1E,
        8'h1F, 8'h06};

    logic                           clk;
    logic                           reset;
    logic                           in_valid;
    logic                           in_ready;
    logic [decode_pkg::BYTE_W-1:0]  in_byte0;
    logic [decode_pkg::BYTE_W-1:0]  in_byte1;
    logic [decode_pkg::BYTE_W-1:0]  in_byte2;
    logic                           out_valid;
    logic                           out_ready;
    logic                           recognized;
    logic                           s;
    logic                           w;
    logic [decode_pkg::GPR_W-1:0]   gpr;
    logic [decode_pkg::SREG3_W-1:0] sreg3;
    logic [decode_pkg::SREG2_W-1:0] sreg2;
    logic [decode_pkg::MOD_W-1:0]   mod;
    logic [decode_pkg::RM_W-1:0]    rm;

    decode_pkg::field_payload_t expected_q[$];
    logic [23:0]                window_q[$];
    logic                       taken;
    int                         cycles;
    int                         errors;
    int                         results;
    int                         tests_run;

    `include "decode_model.svh"

    field_decode_top uut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_byte0   (in_byte0),
        .in_byte1   (in_byte1),
        .in_byte2   (in_byte2),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .recognized (recognized),
        .s          (s),
        .w          (w),
        .gpr        (gpr),
        .sreg3      (sreg3),
        .sreg2      (sreg2),
        .mod        (mod),
        .rm         (rm)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================
    // Stimulus helpers
    // ========================================
    task automatic pick_window(input int kind, output logic [7:0] b0, output logic [7:0] b1,
                               output logic [7:0] b2);
        logic [31:0] r;
        logic [31:0] r2;
        int          form;
        r    = $urandom;
        r2   = $urandom;
        b1   = r2[7:0];
        b2   = r2[15:8];
        form = kind;
        if (kind == KIND_MIX) begin
            case (r[31:29]) // Mostly kept forms.
                3'd0, 3'd1: form = KIND_RM;
                3'd2, 3'd3: form = KIND_SHORT;
                3'd4, 3'd5: form = KIND_ESCAPE;
                3'd6:       form = KIND_UNKNOWN;
                default:    form = KIND_MIX;
            endcase
        end
        case (form)
            KIND_RM: begin
                case (r[1:0])
                    2'd0:    b0 = {2'b00, r[4:2], 1'b0, r[6:5]};
                    2'd1:    b0 = {6'b100000, r[3:2]};
                    2'd2:    b0 = {6'b100010, r[3:2]};
                    default: b0 = r[2] ? decode_pkg::OP_MOV_SREG_FROM : decode_pkg::OP_MOV_SREG_TO;
                endcase
            end
            KIND_SHORT: begin
                case (r[1:0])
                    2'd0:    b0 = {3'b010, r[6:2]};
                    2'd1:    b0 = {4'b1011, r[5:2]};
                    2'd2:    b0 = {2'b00, r[4:2], 2'b10, r[5]};
                    default: b0 = SREG2_OPS[r[4:2]];
                endcase
            end
            KIND_ESCAPE: begin
                b0 = decode_pkg::OP_ESCAPE;
                case (r[1:0])
                    2'd0:    b1 = {4'b1011, r[2], 2'b11, r[3]}; // MOVZX, MOVSX.
                    2'd1:    b1 = {7'b1011110, r[2]};
                    2'd2:    b1 = {4'h9, r[5:2]};
                    default: b1 = {4'hA, r[2], 2'b00, r[3]};
                endcase
            end
            KIND_UNKNOWN: begin
                if (r[1]) begin
                    b0 = decode_pkg::OP_ESCAPE;
                    b1 = UNKNOWN_ESC[r[5:2]];
                end else begin
                    b0 = UNKNOWN_ONE[r[5:2]];
                end
            end
            default: b0 = r[7:0];
        endcase
    endtask

    // Ends a run whose results stop arriving.
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles, results stopped arriving", cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ========================================
    // Scoreboard
    // ========================================
    task automatic check_field(input string name, input int got, input int exp,
                               input logic [23:0] win);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s is %0h, expected %0h, window %h %h %h",
                     $time, name, got, exp, win[7:0], win[15:8], win[23:16]);
            errors++;
        end
    endtask

    task automatic check_result();
        decode_pkg::field_payload_t exp;
        logic [23:0]                win;
        if (expected_q.size() == 0) begin
            $display("ERROR: result at %0t with no window pending", $time);
            errors++;
        end else begin
            exp = expected_q.pop_front();
            win = window_q.pop_front();
            check_field("recognized", int'(recognized), int'(exp.recognized), win);
            check_field("s", int'(s), int'(exp.s), win);
            check_field("w", int'(w), int'(exp.w), win);
            check_field("gpr", int'(gpr), int'(exp.gpr), win);
            check_field("sreg3", int'(sreg3), int'(exp.sreg3), win);
            check_field("sreg2", int'(sreg2), int'(exp.sreg2), win);
            check_field("mod", int'(mod), int'(exp.mod), win);
            check_field("rm", int'(rm), int'(exp.rm), win);
            results++;
        end
    endtask

    // Drive at the falling edge, sample a quarter period later.
    task automatic run_test(input string name, input int kind, input int count,
                            input bit stall);
        logic [31:0] rnd;
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        int          sent;
        int          errors_before;
        int          results_before;
        sent           = 0;
        errors_before  = errors;
        results_before = results;
        while (sent < count || in_valid || expected_q.size() != 0) begin
            @(negedge clk);
            rnd = $urandom;
            if (!in_valid || taken) begin
                if (sent < count && (!stall || rnd[1:0] != 2'b00)) begin
                    pick_window(kind, b0, b1, b2);
                    in_byte0 = b0;
                    in_byte1 = b1;
                    in_byte2 = b2;
                    in_valid = 1'b1;
                end else begin
                    in_valid = 1'b0;
                end
            end
            out_ready = stall ? (rnd[3:2] != 2'b00) : 1'b1;
            #(CLK_PERIOD / 4);
            taken = in_valid && in_ready;
            if (taken) begin
                expected_q.push_back(model_decode(in_byte0, in_byte1, in_byte2));
                window_q.push_back({in_byte2, in_byte1, in_byte0});
                sent++;
            end
            if (!stall && in_valid && !in_ready) begin
                $display("ERROR: in_ready low at %0t during back-to-back stream", $time);
                errors++;
            end
            if (out_valid && out_ready) check_result();
        end
        tests_run++;
        $display("test %-10s %0d windows, %0d results, %0d errors", name, count,
                 results - results_before, errors - errors_before);
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_byte0  = '0;
        in_byte1  = '0;
        in_byte2  = '0;
        out_ready = 1'b0;
        taken     = 1'b0;
        errors    = 0;
        results   = 0;
        tests_run = 0;
        void'($urandom(SEED));

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (out_valid || !in_ready) begin
            $display("ERROR: after reset out_valid is %0b and in_ready is %0b",
                     out_valid, in_ready);
            errors++;
        end

        run_test("rm_forms", KIND_RM, N_RM, 1'b1);
        run_test("short", KIND_SHORT, N_SHORT, 1'b1);
        run_test("escape", KIND_ESCAPE, N_ESCAPE, 1'b1);
        run_test("unknown", KIND_UNKNOWN, N_UNKNOWN, 1'b1);
        run_test("backpress", KIND_MIX, N_MIX, 1'b1);
        run_test("stream", KIND_MIX, N_STREAM, 1'b0);

        // Nothing may follow once every window is answered.
        repeat (4) begin
            @(negedge clk);
            if (out_valid) begin
                $display("ERROR: extra result after all windows were answered");
                errors++;
            end
        end

        $display("tests %0d, windows %0d, results %0d, errors %0d, assertion failures %0d",
                 tests_run, TOTAL, results, errors, uut.u_chk.fail_count);
        if (errors == 0 && results == TOTAL && uut.u_chk.fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
+incdir+bench
hw/decode_pkg.sv
hw/opcode_classify.sv
hw/field_extract.sv
hw/pipe_stage.sv
hw/field_decode_top.sv
bench/field_decode_chk.sv
bench/field_decode_tb.sv

// File: Makefile
# Verilator build, run and lint for the x86 field decoder testbench.
TOP   := field_decode_tb
BUILD := obj_dir

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir $(BUILD)

run: build
	-./$(BUILD)/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f sources.f --top-module $(TOP)

clean:
	rm -rf $(BUILD) sim.log
